// File: include/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data path and register width
`define CORE_XLEN 64

// Byte address width on the bus
`define CORE_ADDR_W 16

// Register count, the last one reads as zero
`define CORE_NREGS 32

// First fetch address
`define CORE_RESET_PC 'h0

`endif

// File: source/isa_pkg.sv
package isa_pkg;

   // ALU operations
   typedef enum logic [2:0]
   {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_ORR,
      ALU_PASS_B
   } alu_op_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Opcodes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam logic [10:0] OP_ADD  = 11'b100_0101_1000;
   localparam logic [10:0] OP_SUB  = 11'b110_0101_1000;
   localparam logic [10:0] OP_AND  = 11'b100_0101_0000;
   localparam logic [10:0] OP_ORR  = 11'b101_0101_0000;
   localparam logic [10:0] OP_LDUR = 11'b111_1100_0010;
   localparam logic [10:0] OP_STUR = 11'b111_1100_0000;
   localparam logic [9:0]  OP_ADDI = 10'b10_0100_0100;
   localparam logic [7:0]  OP_CBZ  = 8'b1011_0100;

   localparam int REG_W = 5;
   localparam logic [REG_W-1:0] XZR = 5'd31;

   // Instruction field positions
   localparam int OP11_LSB  = 21;
   localparam int OP10_LSB  = 22;
   localparam int OP8_LSB   = 24;
   localparam int RD_LSB    = 0;
   localparam int RN_LSB    = 5;
   localparam int RM_LSB    = 16;
   localparam int IMM12_LSB = 10;
   localparam int IMM12_W   = 12;
   localparam int DADDR_LSB = 12;
   localparam int DADDR_W   = 9;
   localparam int IMM19_LSB = 5;
   localparam int IMM19_W   = 19;

endpackage

// File: source/core_pkg.sv
`include "core_defines.svh"

package core_pkg;
   import isa_pkg::*;

   typedef logic [`CORE_XLEN-1:0] xword_t;
   typedef logic [REG_W-1:0]      reg_idx_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stage payloads
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef struct packed
   {
      logic        valid;
      xword_t      pc;
      logic [31:0] instr;
   } if_id_t;

   typedef struct packed
   {
      logic     valid;
      alu_op_t  alu_op;
      logic     alu_src;
      logic     mem_write;
      logic     mem_read;
      logic     mem_to_reg;
      logic     reg_write;
      logic     branch;
      xword_t   pc;
      xword_t   rd1;
      xword_t   rd2;
      xword_t   imm;
      reg_idx_t rn;
      reg_idx_t rm;
      reg_idx_t rd;
   } id_ex_t;

   typedef struct packed
   {
      logic     valid;
      logic     mem_write;
      logic     mem_read;
      logic     mem_to_reg;
      logic     reg_write;
      xword_t   alu_result;
      xword_t   store_data;
      reg_idx_t rd;
   } ex_mem_t;

   typedef struct packed
   {
      logic     valid;
      logic     reg_write;
      reg_idx_t rd;
      xword_t   data;
   } mem_wb_t;

   // Wishbone classic
   typedef struct packed
   {
      logic                    cyc;
      logic                    stb;
      logic                    we;
      logic [`CORE_ADDR_W-1:0] adr;
      xword_t                  dat_w;
      logic [7:0]              sel;
   } wb_req_t;

   typedef struct packed
   {
      logic   ack;
      xword_t dat_r;
   } wb_rsp_t;

endpackage

// File: source/wb_arbiter.sv
module wb_arbiter
   import core_pkg::*;
(
   input  logic    clock,
   input  logic    reset,
   input  wb_req_t fetch_req_i,
   output wb_rsp_t fetch_rsp_o,
   input  wb_req_t data_req_i,
   output wb_rsp_t data_rsp_o,
   output wb_req_t bus_req_o,
   input  wb_rsp_t bus_rsp_i
);

   logic busy;
   logic owner_data;
   logic grant_data;

   // Data master wins an idle bus
   assign grant_data = busy ? owner_data : data_req_i.cyc;

   assign bus_req_o = grant_data ? data_req_i : fetch_req_i;

   always_comb
   begin
      fetch_rsp_o.dat_r = bus_rsp_i.dat_r;
      fetch_rsp_o.ack   = bus_rsp_i.ack && !grant_data;
      data_rsp_o.dat_r  = bus_rsp_i.dat_r;
      data_rsp_o.ack    = bus_rsp_i.ack && grant_data;
   end

   // Grant held from the first request cycle up to its ack
   always_ff @(posedge clock, negedge reset)
   begin
      if (!reset)
      begin
         busy       <= 1'b0;
         owner_data <= 1'b0;
      end
      else if (bus_rsp_i.ack)
      begin
         busy <= 1'b0;
      end
      else if (!busy && bus_req_o.cyc)
      begin
         busy       <= 1'b1;
         owner_data <= grant_data;
      end
   end

endmodule

// File: source/fetch_unit.sv
`include "core_defines.svh"

module fetch_unit
   import core_pkg::*;
(
   input  logic    clock,
   input  logic    reset,
   input  logic    step_i,
   input  logic    hold_i,
   input  logic    redirect_i,
   input  xword_t  redirect_pc_i,
   output wb_req_t bus_req_o,
   input  wb_rsp_t bus_rsp_i,
   output logic    instr_valid_o,
   output if_id_t  fetched_o
);

   xword_t      pc;
   xword_t      req_pc;
   xword_t      fetch_pc;
   logic        running;
   logic        inflight;
   logic        stale;
   logic        buf_valid;
   xword_t      buf_pc;
   logic [31:0] buf_instr;
   logic [31:0] lane;
   logic        advance;
   logic        take;
   logic        fill;

   assign advance = step_i && !hold_i;
   assign take    = step_i && redirect_i;
   assign fill    = bus_rsp_i.ack && !stale && !take;

   // Address frozen while a transfer waits for its ack
   assign fetch_pc = inflight ? req_pc : pc;
   assign lane     = fetch_pc[2] ? bus_rsp_i.dat_r[`CORE_XLEN-1:32] : bus_rsp_i.dat_r[31:0];

   always_comb
   begin
      // No request until reset is released
      bus_req_o.cyc   = running && (inflight || !buf_valid || advance);
      bus_req_o.stb   = bus_req_o.cyc;
      bus_req_o.we    = 1'b0;
      bus_req_o.adr   = fetch_pc[`CORE_ADDR_W-1:0];
      bus_req_o.dat_w = '0;
      bus_req_o.sel   = fetch_pc[2] ? 8'hf0 : 8'h0f;
   end

   always_ff @(posedge clock, negedge reset)
   begin
      if (!reset)
      begin
         pc        <= `CORE_RESET_PC;
         running   <= 1'b0;
         inflight  <= 1'b0;
         stale     <= 1'b0;
         buf_valid <= 1'b0;
      end
      else
      begin
         running  <= 1'b1;
         inflight <= bus_req_o.cyc && !bus_rsp_i.ack;
         if (take)
            pc <= redirect_pc_i;
         else if (fill)
            pc <= fetch_pc + xword_t'(4);
         // Wrong-path response still owed by the bus
         if (bus_rsp_i.ack)
            stale <= 1'b0;
         else if (take && bus_req_o.cyc)
            stale <= 1'b1;
         if (fill)
            buf_valid <= 1'b1;
         else if (advance || take)
            buf_valid <= 1'b0;
      end
   end

   always_ff @(posedge clock)
   begin
      if (!inflight)
         req_pc <= pc;
      if (fill)
      begin
         buf_pc    <= fetch_pc;
         buf_instr <= lane;
      end
   end

   assign instr_valid_o = buf_valid;

   always_comb
   begin
      fetched_o.valid = buf_valid;
      fetched_o.pc    = buf_pc;
      fetched_o.instr = buf_instr;
   end

endmodule

// File: source/decode_unit.sv
`include "core_defines.svh"

module decode_unit
   import isa_pkg::*, core_pkg::*;
(
   input  logic     clock,
   input  logic     reset,
   input  logic     step_i,
   input  if_id_t   if_id_i,
   input  mem_wb_t  wb_i,
   input  reg_idx_t ex_dest_i,
   input  logic     ex_mem_read_i,
   output id_ex_t   id_ex_o,
   output logic     load_stall_o
);

   logic [31:0] instr;
   logic [10:0] op11;
   reg_idx_t    rn;
   reg_idx_t    rm;
   reg_idx_t    rt;
   reg_idx_t    r2;
   logic        is_rtype;
   logic        is_addi;
   logic        is_ldur;
   logic        is_stur;
   logic        is_cbz;
   logic        uses_rn;
   logic        uses_r2;
   logic        wb_hit;
   xword_t      rd1;
   xword_t      rd2;
   xword_t      imm;
   xword_t      regs [`CORE_NREGS];

   assign instr = if_id_i.instr;
   assign op11  = instr[OP11_LSB +: 11];
   assign rn    = instr[RN_LSB +: REG_W];
   assign rm    = instr[RM_LSB +: REG_W];
   assign rt    = instr[RD_LSB +: REG_W];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Opcode classes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign is_rtype = if_id_i.valid && (op11 inside {OP_ADD, OP_SUB, OP_AND, OP_ORR});
   assign is_addi  = if_id_i.valid && (instr[OP10_LSB +: 10] == OP_ADDI);
   assign is_ldur  = if_id_i.valid && (op11 == OP_LDUR);
   assign is_stur  = if_id_i.valid && (op11 == OP_STUR);
   assign is_cbz   = if_id_i.valid && (instr[OP8_LSB +: 8] == OP_CBZ);

   // STUR and CBZ read Rt through the second port
   assign r2      = (is_stur || is_cbz) ? rt : rm;
   assign uses_rn = is_rtype || is_addi || is_ldur || is_stur;
   assign uses_r2 = is_rtype || is_stur || is_cbz;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Register file
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign wb_hit = wb_i.valid && wb_i.reg_write && (wb_i.rd != XZR);

   always_ff @(posedge clock, negedge reset)
   begin
      if (!reset)
      begin
         for (int i = 0; i < `CORE_NREGS; i++)
            regs[i] <= '0;
      end
      else if (step_i && wb_hit)
      begin
         regs[wb_i.rd] <= wb_i.data;
      end
   end

   // Pending writeback seen before it lands
   assign rd1 = (rn == XZR) ? '0 : (wb_hit && wb_i.rd == rn) ? wb_i.data : regs[rn];
   assign rd2 = (r2 == XZR) ? '0 : (wb_hit && wb_i.rd == r2) ? wb_i.data : regs[r2];

   // Immediates
   always_comb
   begin
      if (is_cbz)
         imm = {{(`CORE_XLEN-IMM19_W-2){instr[IMM19_LSB+IMM19_W-1]}},
                instr[IMM19_LSB +: IMM19_W], 2'b00};
      else if (is_addi)
         imm = {{(`CORE_XLEN-IMM12_W){instr[IMM12_LSB+IMM12_W-1]}},
                instr[IMM12_LSB +: IMM12_W]};
      else
         imm = {{(`CORE_XLEN-DADDR_W){instr[DADDR_LSB+DADDR_W-1]}},
                instr[DADDR_LSB +: DADDR_W]};
   end

   // Load in ID/EX feeding this instruction
   assign load_stall_o = ex_mem_read_i && (ex_dest_i != XZR) &&
                         ((uses_rn && rn == ex_dest_i) || (uses_r2 && r2 == ex_dest_i));

   always_comb
   begin
      id_ex_o = '0;
      if (!load_stall_o && (uses_rn || is_cbz))
      begin
         id_ex_o.valid      = 1'b1;
         id_ex_o.alu_src    = is_addi || is_ldur || is_stur;
         id_ex_o.mem_write  = is_stur;
         id_ex_o.mem_read   = is_ldur;
         id_ex_o.mem_to_reg = is_ldur;
         id_ex_o.reg_write  = is_rtype || is_addi || is_ldur;
         id_ex_o.branch     = is_cbz;
         id_ex_o.pc         = if_id_i.pc;
         id_ex_o.rd1        = rd1;
         id_ex_o.rd2        = rd2;
         id_ex_o.imm        = imm;
         id_ex_o.rn         = rn;
         id_ex_o.rm         = r2;
         id_ex_o.rd         = rt;
         if (is_cbz)
            id_ex_o.alu_op = ALU_PASS_B;
         else if (is_rtype && op11 == OP_SUB)
            id_ex_o.alu_op = ALU_SUB;
         else if (is_rtype && op11 == OP_AND)
            id_ex_o.alu_op = ALU_AND;
         else if (is_rtype && op11 == OP_ORR)
            id_ex_o.alu_op = ALU_ORR;
         else
            id_ex_o.alu_op = ALU_ADD;
      end
   end

endmodule

// File: source/pipe_reg.sv
module pipe_reg
#(
   parameter type payload_t = logic
)
(
   input  logic     clock,
   input  logic     reset,
   input  logic     step_i,
   input  logic     hold_i,
   input  logic     flush_i,
   input  payload_t d_i,
   output payload_t q_o
);

   // Bubble is the all-zero payload
   always_ff @(posedge clock, negedge reset)
   begin
      if (!reset)
      begin
         q_o <= '0;
      end
      else if (step_i)
      begin
         if (flush_i)
            q_o <= '0;
         else if (!hold_i)
            q_o <= d_i;
      end
   end

endmodule

// File: source/execute_unit.sv
module execute_unit
   import isa_pkg::*, core_pkg::*;
(
   input  id_ex_t  id_ex_i,
   input  ex_mem_t ex_mem_i,
   input  mem_wb_t mem_wb_i,
   output ex_mem_t ex_mem_o,
   output logic    redirect_o,
   output xword_t  redirect_pc_o
);

   logic   ex_fwd;
   logic   wb_fwd;
   xword_t op_a;
   xword_t op_b;
   xword_t fwd_b;
   xword_t result;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Forwarding
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Load data is not ready in EX/MEM, decode stalls instead
   assign ex_fwd = ex_mem_i.valid && ex_mem_i.reg_write && !ex_mem_i.mem_read &&
                   (ex_mem_i.rd != XZR);
   assign wb_fwd = mem_wb_i.valid && mem_wb_i.reg_write && (mem_wb_i.rd != XZR);

   always_comb
   begin
      if (ex_fwd && ex_mem_i.rd == id_ex_i.rn)
         op_a = ex_mem_i.alu_result;
      else if (wb_fwd && mem_wb_i.rd == id_ex_i.rn)
         op_a = mem_wb_i.data;
      else
         op_a = id_ex_i.rd1;

      if (ex_fwd && ex_mem_i.rd == id_ex_i.rm)
         fwd_b = ex_mem_i.alu_result;
      else if (wb_fwd && mem_wb_i.rd == id_ex_i.rm)
         fwd_b = mem_wb_i.data;
      else
         fwd_b = id_ex_i.rd2;
   end

   assign op_b = id_ex_i.alu_src ? id_ex_i.imm : fwd_b;

   // ALU, also the LDUR and STUR address
   always_comb
   begin
      case (id_ex_i.alu_op)
         ALU_SUB:    result = op_a - op_b;
         ALU_AND:    result = op_a & op_b;
         ALU_ORR:    result = op_a | op_b;
         ALU_PASS_B: result = op_b;
         default:    result = op_a + op_b;
      endcase
   end

   always_comb
   begin
      ex_mem_o.valid      = id_ex_i.valid;
      ex_mem_o.mem_write  = id_ex_i.mem_write;
      ex_mem_o.mem_read   = id_ex_i.mem_read;
      ex_mem_o.mem_to_reg = id_ex_i.mem_to_reg;
      ex_mem_o.reg_write  = id_ex_i.reg_write;
      ex_mem_o.alu_result = result;
      ex_mem_o.store_data = fwd_b;
      ex_mem_o.rd         = id_ex_i.rd;
   end

   // CBZ taken on a zero Rt
   assign redirect_o    = id_ex_i.valid && id_ex_i.branch && (result == '0);
   assign redirect_pc_o = id_ex_i.pc + id_ex_i.imm;

endmodule

// File: source/memory_unit.sv
`include "core_defines.svh"

module memory_unit
   import core_pkg::*;
(
   input  logic    clock,
   input  logic    reset,
   input  ex_mem_t ex_mem_i,
   input  logic    instr_valid_i,
   output wb_req_t bus_req_o,
   input  wb_rsp_t bus_rsp_i,
   output logic    done_o,
   output mem_wb_t mem_wb_o
);

   logic   mem_op;
   logic   finished;
   logic   access_done;
   xword_t load_q;
   xword_t load_data;

   assign mem_op      = ex_mem_i.valid && (ex_mem_i.mem_read || ex_mem_i.mem_write);
   assign access_done = !mem_op || finished || bus_rsp_i.ack;

   // Pipeline step, access complete and an instruction waiting in fetch
   assign done_o = access_done && instr_valid_i;

   always_comb
   begin
      bus_req_o.cyc   = mem_op && !finished;
      bus_req_o.stb   = bus_req_o.cyc;
      bus_req_o.we    = ex_mem_i.mem_write;
      bus_req_o.adr   = ex_mem_i.alu_result[`CORE_ADDR_W-1:0];
      bus_req_o.dat_w = ex_mem_i.store_data;
      bus_req_o.sel   = 8'hff;
   end

   // Finished access waits here for the step
   always_ff @(posedge clock, negedge reset)
   begin
      if (!reset)
         finished <= 1'b0;
      else if (done_o)
         finished <= 1'b0;
      else if (bus_rsp_i.ack)
         finished <= 1'b1;
   end

   always_ff @(posedge clock)
   begin
      if (bus_rsp_i.ack)
         load_q <= bus_rsp_i.dat_r;
   end

   assign load_data = finished ? load_q : bus_rsp_i.dat_r;

   always_comb
   begin
      mem_wb_o.valid     = ex_mem_i.valid;
      mem_wb_o.reg_write = ex_mem_i.reg_write;
      mem_wb_o.rd        = ex_mem_i.rd;
      mem_wb_o.data      = ex_mem_i.mem_to_reg ? load_data : ex_mem_i.alu_result;
   end

endmodule

// File: source/legv8_core.sv
module legv8_core
   import core_pkg::*;
(
   input  logic    clock,
   input  logic    reset,
   output wb_req_t bus_req_o,
   input  wb_rsp_t bus_rsp_i
);

   logic    step;
   logic    instr_valid;
   logic    load_stall;
   logic    redirect;
   xword_t  redirect_pc;
   wb_req_t fetch_req;
   wb_rsp_t fetch_rsp;
   wb_req_t data_req;
   wb_rsp_t data_rsp;
   if_id_t  fetched;
   if_id_t  if_id_q;
   id_ex_t  id_ex_d;
   id_ex_t  id_ex_q;
   ex_mem_t ex_mem_d;
   ex_mem_t ex_mem_q;
   mem_wb_t mem_wb_d;
   mem_wb_t mem_wb_q;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stages
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   fetch_unit fetch
   (
      .clock         (clock),
      .reset         (reset),
      .step_i        (step),
      .hold_i        (load_stall),
      .redirect_i    (redirect),
      .redirect_pc_i (redirect_pc),
      .bus_req_o     (fetch_req),
      .bus_rsp_i     (fetch_rsp),
      .instr_valid_o (instr_valid),
      .fetched_o     (fetched)
   );

   pipe_reg #(.payload_t(if_id_t)) if_id_reg
   (
      .clock   (clock),
      .reset   (reset),
      .step_i  (step),
      .hold_i  (load_stall),
      .flush_i (redirect),
      .d_i     (fetched),
      .q_o     (if_id_q)
   );

   // Stalled decode hands a bubble to ID/EX
   decode_unit decode
   (
      .clock         (clock),
      .reset         (reset),
      .step_i        (step),
      .if_id_i       (if_id_q),
      .wb_i          (mem_wb_q),
      .ex_dest_i     (id_ex_q.rd),
      .ex_mem_read_i (id_ex_q.mem_read),
      .id_ex_o       (id_ex_d),
      .load_stall_o  (load_stall)
   );

   pipe_reg #(.payload_t(id_ex_t)) id_ex_reg
   (
      .clock   (clock),
      .reset   (reset),
      .step_i  (step),
      .hold_i  (1'b0),
      .flush_i (redirect),
      .d_i     (id_ex_d),
      .q_o     (id_ex_q)
   );

   execute_unit execute
   (
      .id_ex_i       (id_ex_q),
      .ex_mem_i      (ex_mem_q),
      .mem_wb_i      (mem_wb_q),
      .ex_mem_o      (ex_mem_d),
      .redirect_o    (redirect),
      .redirect_pc_o (redirect_pc)
   );

   pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg
   (
      .clock   (clock),
      .reset   (reset),
      .step_i  (step),
      .hold_i  (1'b0),
      .flush_i (1'b0),
      .d_i     (ex_mem_d),
      .q_o     (ex_mem_q)
   );

   memory_unit memory
   (
      .clock         (clock),
      .reset         (reset),
      .ex_mem_i      (ex_mem_q),
      .instr_valid_i (instr_valid),
      .bus_req_o     (data_req),
      .bus_rsp_i     (data_rsp),
      .done_o        (step),
      .mem_wb_o      (mem_wb_d)
   );

   pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg
   (
      .clock   (clock),
      .reset   (reset),
      .step_i  (step),
      .hold_i  (1'b0),
      .flush_i (1'b0),
      .d_i     (mem_wb_d),
      .q_o     (mem_wb_q)
   );

   // Shared external port
   wb_arbiter arbiter
   (
      .clock       (clock),
      .reset       (reset),
      .fetch_req_i (fetch_req),
      .fetch_rsp_o (fetch_rsp),
      .data_req_i  (data_req),
      .data_rsp_o  (data_rsp),
      .bus_req_o   (bus_req_o),
      .bus_rsp_i   (bus_rsp_i)
   );

endmodule

// File: verification/legv8_core_tb.sv
`include "core_defines.svh"

module legv8_core_tb
   import core_pkg::*;
();

   localparam int PERIOD       = 100;
   localparam int DRIVE_DLY    = 10;
   localparam int MEM_WORDS    = 1 << (`CORE_ADDR_W - 3);
   localparam int BODY_FIRST   = 9;
   localparam int BODY_LAST    = 56;
   localparam int DUMP_FIRST   = 57;
   localparam int SPIN_IDX     = 65;
   localparam int DATA_BASE    = 'h400;
   localparam int DUMP_OFS     = 'h80;
   localparam int RUN_LIMIT    = 20000;
   localparam int QUIET_CYCLES = 60;
   localparam int MODEL_LIMIT  = 1000;

   // Instruction kinds of the generated program
   localparam int K_ADD  = 0;
   localparam int K_SUB  = 1;
   localparam int K_AND  = 2;
   localparam int K_ORR  = 3;
   localparam int K_ADDI = 4;
   localparam int K_LDUR = 5;
   localparam int K_STUR = 6;
   localparam int K_CBZ  = 7;

   localparam logic [10:0] OPC_ADD  = 11'b10001011000;
   localparam logic [10:0] OPC_SUB  = 11'b11001011000;
   localparam logic [10:0] OPC_AND  = 11'b10001010000;
   localparam logic [10:0] OPC_ORR  = 11'b10101010000;
   localparam logic [10:0] OPC_LDUR = 11'b11111000010;
   localparam logic [10:0] OPC_STUR = 11'b11111000000;
   localparam logic [9:0]  OPC_ADDI = 10'b1001000100;
   localparam logic [7:0]  OPC_CBZ  = 8'b10110100;

   logic    clock;
   logic    reset;
   wb_req_t bus_req;
   wb_rsp_t bus_rsp = '0;

   xword_t mem [MEM_WORDS];
   xword_t model_mem [MEM_WORDS];
   xword_t xr [32];
   int     kind [SPIN_IDX+1];
   int     f_rd [SPIN_IDX+1];
   int     f_rn [SPIN_IDX+1];
   int     f_rm [SPIN_IDX+1];
   int     f_imm [SPIN_IDX+1];

   logic [`CORE_ADDR_W-1:0] exp_addr [$];
   xword_t                  exp_data [$];

   logic [31:0] rng_state;
   int          errors;
   int          checks;
   int          stores_seen;
   int          exp_total;

   // Slave state
   logic   acking;
   logic   waiting;
   int     wait_left;
   xword_t rsp_data;

   legv8_core uut
   (
      .clock     (clock),
      .reset     (reset),
      .bus_req_o (bus_req),
      .bus_rsp_i (bus_rsp)
   );

   always #(PERIOD/2) clock = ~clock;

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic int pick_below(int n);
      return int'(next_rand() % n);
   endfunction

   function automatic xword_t fill_word(int idx);
      logic [15:0] a;
      a = 16'(idx);
      return {a ^ 16'h5a5a, ~a, a + 16'h1357, a[7:0], a[15:8]};
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Program generation
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic [31:0] encode(int k, int rd, int rn, int rm, int imm);
      logic [4:0] d;
      logic [4:0] n;
      logic [4:0] m;
      d = 5'(rd);
      n = 5'(rn);
      m = 5'(rm);
      case (k)
         K_ADD:   return {OPC_ADD, m, 6'd0, n, d};
         K_SUB:   return {OPC_SUB, m, 6'd0, n, d};
         K_AND:   return {OPC_AND, m, 6'd0, n, d};
         K_ORR:   return {OPC_ORR, m, 6'd0, n, d};
         K_ADDI:  return {OPC_ADDI, 12'(imm), n, d};
         K_LDUR:  return {OPC_LDUR, 9'(imm), 2'b00, n, d};
         K_STUR:  return {OPC_STUR, 9'(imm), 2'b00, n, d};
         default: return {OPC_CBZ, 19'(imm), d};
      endcase
   endfunction

   task automatic place_instr(int idx, int k, int rd, int rn, int rm, int imm);
      kind[idx]  = k;
      f_rd[idx]  = rd;
      f_rn[idx]  = rn;
      f_rm[idx]  = rm;
      f_imm[idx] = imm;
      // Two instructions per bus word, lane picked by address bit 2
      mem[idx / 2][32 * (idx % 2) +: 32] = encode(k, rd, rn, rm, imm);
   endtask

   task automatic build_program();
      int last_rd;
      int r;
      int rd;
      int rn;
      int rm;
      int skip;
      place_instr(0, K_ADDI, 9, 31, 0, DATA_BASE);
      for (int i = 1; i <= 8; i++)
         place_instr(i, K_ADDI, i, 31, 0, pick_below(200));
      last_rd = 8;
      for (int i = BODY_FIRST; i <= BODY_LAST; i++)
      begin
         r  = pick_below(16);
         rd = 1 + pick_below(8);
         rn = pick_below(2) ? last_rd : 1 + pick_below(8);
         rm = 1 + pick_below(8);
         // Branch target stays ahead of the dump code
         if (r == 13 && i > BODY_LAST - 3)
            r = 0;
         if (r < 6)
            place_instr(i, K_ADD + pick_below(4), rd, rn, rm, 0);
         else if (r < 9)
            place_instr(i, K_ADDI, rd, rn, 0, pick_below(601) - 300);
         else if (r < 11)
            place_instr(i, K_LDUR, rd, 9, 0, 8 * pick_below(8));
         else if (r < 13)
            place_instr(i, K_STUR, rn, 9, 0, 8 * pick_below(8));
         else if (r == 13)
         begin
            skip = 1 + pick_below(3);
            place_instr(i, K_CBZ, (pick_below(3) == 0) ? 31 : rn, 31, 0, skip + 1);
         end
         else if (r == 14)
            place_instr(i, K_SUB, rd, last_rd, last_rd, 0);
         else
            place_instr(i, K_ADDI, rd, last_rd, 0, pick_below(64));
         if (kind[i] != K_STUR && kind[i] != K_CBZ)
            last_rd = rd;
      end
      for (int i = 1; i <= 8; i++)
         place_instr(DUMP_FIRST + i - 1, K_STUR, i, 9, 0, DUMP_OFS + 8 * (i - 1));
      // Endless loop on itself
      place_instr(SPIN_IDX, K_CBZ, 31, 31, 0, 0);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic run_model();
      int     pc_idx;
      int     steps;
      int     rd;
      int     rn;
      int     rm;
      xword_t imm;
      xword_t sum;
      pc_idx = 0;
      steps  = 0;
      for (int r = 0; r < 32; r++)
         xr[r] = '0;
      for (int w = 0; w < MEM_WORDS; w++)
         model_mem[w] = mem[w];
      while (pc_idx != SPIN_IDX && steps < MODEL_LIMIT)
      begin
         rd  = f_rd[pc_idx];
         rn  = f_rn[pc_idx];
         rm  = f_rm[pc_idx];
         imm = xword_t'(longint'(f_imm[pc_idx]));
         sum = xr[rn] + imm;
         case (kind[pc_idx])
            K_ADD:  xr[rd] = xr[rn] + xr[rm];
            K_SUB:  xr[rd] = xr[rn] - xr[rm];
            K_AND:  xr[rd] = xr[rn] & xr[rm];
            K_ORR:  xr[rd] = xr[rn] | xr[rm];
            K_ADDI: xr[rd] = sum;
            K_LDUR: xr[rd] = model_mem[sum[`CORE_ADDR_W-1:3]];
            K_STUR:
            begin
               exp_addr.push_back(sum[`CORE_ADDR_W-1:0]);
               exp_data.push_back(xr[rd]);
               model_mem[sum[`CORE_ADDR_W-1:3]] = xr[rd];
            end
            default: ;
         endcase
         xr[31] = '0;
         if (kind[pc_idx] == K_CBZ && xr[rd] == '0)
            pc_idx += f_imm[pc_idx];
         else
            pc_idx++;
         steps++;
      end
      assert (pc_idx == SPIN_IDX)
      else
      begin
         errors++;
         $display("reference model did not reach the final loop");
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Wishbone memory
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic check_store(logic [`CORE_ADDR_W-1:0] adr, xword_t data);
      logic [`CORE_ADDR_W-1:0] want_adr;
      xword_t                  want_data;
      stores_seen++;
      assert (exp_addr.size() > 0)
      else
      begin
         errors++;
         $display("store to %h with data %h after the expected stream ended", adr, data);
      end
      if (exp_addr.size() > 0)
      begin
         want_adr  = exp_addr.pop_front();
         want_data = exp_data.pop_front();
         checks++;
         assert (adr == want_adr)
         else
         begin
            errors++;
            $display("** Error store_addr #%0d: expected %h, actual %h",
                     stores_seen, want_adr, adr);
         end
         checks++;
         assert (data == want_data)
         else
         begin
            errors++;
            $display("** Error store_data #%0d: expected %h, actual %h",
                     stores_seen, want_data, data);
         end
      end
   endtask

   task automatic serve_transfer();
      int         word;
      logic [7:0] want_sel;
      word = int'(bus_req.adr >> 3);
      // Fetches sit below the data region and read one 32-bit lane
      if (bus_req.we || bus_req.adr >= DATA_BASE)
         want_sel = 8'hff;
      else if (bus_req.adr[2])
         want_sel = 8'hf0;
      else
         want_sel = 8'h0f;
      checks++;
      assert (bus_req.sel == want_sel)
      else
      begin
         errors++;
         $display("** Error bus_sel at %h: expected %h, actual %h",
                  bus_req.adr, want_sel, bus_req.sel);
      end
      if (bus_req.we)
      begin
         check_store(bus_req.adr, bus_req.dat_w);
         mem[word] = bus_req.dat_w;
      end
      else
         rsp_data = mem[word];
   endtask

   // Request seen at the edge is answered after 0 to 2 wait states
   always @(posedge clock)
   begin
      if (!reset)
      begin
         acking  = 1'b0;
         waiting = 1'b0;
      end
      else if (acking)
      begin
         acking = 1'b0;
      end
      else if (bus_req.cyc && bus_req.stb)
      begin
         if (!waiting)
         begin
            waiting   = 1'b1;
            wait_left = pick_below(3);
         end
         if (wait_left == 0)
         begin
            waiting = 1'b0;
            acking  = 1'b1;
            serve_transfer();
         end
         else
            wait_left--;
      end
      #DRIVE_DLY;
      bus_rsp.ack   = acking;
      bus_rsp.dat_r = acking ? rsp_data : '0;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Bus stays idle while reset is held
   task automatic hold_reset();
      for (int c = 0; c < 5; c++)
      begin
         @(posedge clock);
         #DRIVE_DLY;
         checks++;
         assert (!bus_req.cyc && !bus_req.stb)
         else
         begin
            errors++;
            $display("bus request raised in reset cycle %0d", c);
         end
      end
      reset = 1'b1;
   endtask

   task automatic wait_first_fetch();
      int cycles;
      cycles = 0;
      @(negedge clock);
      while (!bus_req.cyc && cycles < 20)
      begin
         @(negedge clock);
         cycles++;
      end
      assert (bus_req.cyc)
      else
      begin
         errors++;
         $display("no bus request within %0d cycles after reset", cycles);
      end
      checks++;
      assert (!bus_req.we && bus_req.adr == `CORE_ADDR_W'(`CORE_RESET_PC))
      else
      begin
         errors++;
         $display("** Error first_fetch: expected read at %h, actual we %b at %h",
                  `CORE_ADDR_W'(`CORE_RESET_PC), bus_req.we, bus_req.adr);
      end
   endtask

   task automatic wait_for_stores();
      int cycles;
      cycles = 0;
      while (stores_seen < exp_total && cycles < RUN_LIMIT)
      begin
         @(negedge clock);
         cycles++;
      end
      assert (stores_seen >= exp_total)
      else
      begin
         errors++;
         $display("timed out after %0d cycles with %0d of %0d stores seen",
                  cycles, stores_seen, exp_total);
      end
   endtask

   task automatic check_quiet_and_dump();
      int base;
      repeat (QUIET_CYCLES) @(negedge clock);
      checks++;
      assert (stores_seen == exp_total)
      else
      begin
         errors++;
         $display("** Error store_count: expected %0d, actual %0d", exp_total, stores_seen);
      end
      base = (DATA_BASE + DUMP_OFS) / 8;
      for (int i = 1; i <= 8; i++)
      begin
         checks++;
         assert (mem[base + i - 1] == xr[i])
         else
         begin
            errors++;
            $display("** Error dump X%0d: expected %h, actual %h", i, xr[i], mem[base + i - 1]);
         end
      end
   endtask

   initial
   begin
      rng_state   = 32'd59;
      errors      = 0;
      checks      = 0;
      stores_seen = 0;
      clock       = 1'b0;
      reset       = 1'b0;
      for (int w = 0; w < MEM_WORDS; w++)
         mem[w] = fill_word(w);
      build_program();
      run_model();
      exp_total = exp_addr.size();
      hold_reset();
      wait_first_fetch();
      wait_for_stores();
      check_quiet_and_dump();
      $display("checks %0d, errors %0d, stores %0d of %0d",
               checks, errors, stores_seen, exp_total);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// File: legv8_core.f
+incdir+include
source/isa_pkg.sv
source/core_pkg.sv
source/wb_arbiter.sv
source/fetch_unit.sv
source/decode_unit.sv
source/pipe_reg.sv
source/execute_unit.sv
source/memory_unit.sv
source/legv8_core.sv
verification/legv8_core_tb.sv

// File: Makefile
TOP := legv8_core_tb
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): legv8_core.f $(wildcard source/*.sv) $(wildcard include/*.svh) $(wildcard verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f legv8_core.f --top-module $(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf obj_dir
